// ==== verification/program_input.hex ====
// Words from 0: program, one instruction per line. At word 0xc0: store count,
// then one expected store per line: word address, data on enabled lanes, byte enables
12300093  // 00 addi x1, x0, 0x123
FFB00113  // 04 addi x2, x0, -5
002081B3  // 08 add  x3, x1, x2
40208233  // 0c sub  x4, x1, x2
40115293  // 10 srai x5, x2, 1
00415313  // 14 srli x6, x2, 4
00809393  // 18 slli x7, x1, 8
00112433  // 1c slt  x8, x2, x1
001134B3  // 20 sltu x9, x2, x1
0F00C513  // 24 xori x10, x1, 0x0f0
87654637  // 28 lui  x12, 0x87654
00001697  // 2c auipc x13, 1
32160713  // 30 addi x14, x12, 0x321
20302023  // 34 sw x3, 0x200(x0)
20402223  // 38 sw x4, 0x204(x0)
20502423  // 3c sw x5, 0x208(x0)
20602623  // 40 sw x6, 0x20c(x0)
20702823  // 44 sw x7, 0x210(x0)
20A02A23  // 48 sw x10, 0x214(x0)
20C02C23  // 4c sw x12, 0x218(x0)
20D02E23  // 50 sw x13, 0x21c(x0)
22800023  // 54 sb x8, 0x220(x0)
229000A3  // 58 sb x9, 0x221(x0)
22E00123  // 5c sb x14, 0x222(x0)
22E001A3  // 60 sb x14, 0x223(x0)
22E01323  // 64 sh x14, 0x226(x0)
21B00783  // 68 lb  x15, 0x21b(x0)
21B04803  // 6c lbu x16, 0x21b(x0)
21A01883  // 70 lh  x17, 0x21a(x0)
21A05903  // 74 lhu x18, 0x21a(x0)
22F02423  // 78 sw x15, 0x228(x0)
23002623  // 7c sw x16, 0x22c(x0)
23102823  // 80 sw x17, 0x230(x0)
23202A23  // 84 sw x18, 0x234(x0)
00108463  // 88 beq  x1, x1, +8 (taken)
2E002823  // 8c sw x0, 0x2f0(x0), skipped
00109463  // 90 bne  x1, x1, +8 (not taken)
001A0A13  // 94 addi x20, x20, 1
00114463  // 98 blt  x2, x1, +8 (taken)
002A0A13  // 9c addi x20, x20, 2, skipped
00115463  // a0 bge  x2, x1, +8 (not taken)
004A0A13  // a4 addi x20, x20, 4
0020E463  // a8 bltu x1, x2, +8 (taken)
008A0A13  // ac addi x20, x20, 8, skipped
0020F463  // b0 bgeu x1, x2, +8 (not taken)
010A0A13  // b4 addi x20, x20, 16
00800AEF  // b8 jal  x21, +8
020A0A13  // bc addi x20, x20, 32, skipped
0C900B67  // c0 jalr x22, 0xc9(x0), lands on 0xc8
040A0A13  // c4 addi x20, x20, 64, skipped
23402C23  // c8 sw x20, 0x238(x0)
23502E23  // cc sw x21, 0x23c(x0)
25602023  // d0 sw x22, 0x240(x0)
3E002E23  // d4 sw x0, 0x3fc(x0), finish
0000006F  // d8 jal x0, 0
@0C0
00000014
00000200 0000011E 0000000F  // add
00000204 00000128 0000000F  // sub
00000208 FFFFFFFD 0000000F  // srai
0000020C 0FFFFFFF 0000000F  // srli
00000210 00012300 0000000F  // slli
00000214 000001D3 0000000F  // xori
00000218 87654000 0000000F  // lui
0000021C 0000102C 0000000F  // auipc
00000220 00000001 00000001  // slt, byte lane 0
00000220 00000000 00000002  // sltu, byte lane 1
00000220 00210000 00000004  // byte lane 2
00000220 21000000 00000008  // byte lane 3
00000224 43210000 0000000C  // upper halfword
00000228 FFFFFF87 0000000F  // lb
0000022C 00000087 0000000F  // lbu
00000230 FFFF8765 0000000F  // lh
00000234 00008765 0000000F  // lhu
00000238 00000015 0000000F  // branch markers
0000023C 000000BC 0000000F  // jal link
00000240 000000C4 0000000F  // jalr link

// ==== list.f ====
src/core_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/core.sv
verification/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - src/core_pkg.sv
  - src/fetch_stage.sv
  - src/register_file.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/core.sv
  - target: test
    files:
      - verification/core_tb.sv

// ==== verification/core_tb.sv ====
// Testbench for the RV32I core: bus memory model with random acknowledge
// delay and store checks against the expected list in the data file
`timescale 1ns/1ns

module core_tb
  import core_pkg::*;
();

  localparam int mem_words = 256;
  localparam int list_base = 192;
  localparam int max_stores = 21;
  localparam int request_timeout = 50;
  localparam int access_limit = 2000;
  localparam logic [xlen-1:0] finish_addr = 32'h0000_03fc;
  localparam logic [15:0] lfsr_seed = 16'd41084;

  logic            clock;
  logic            reset;
  logic [xlen-1:0] rd_data;
  logic            mem_ack;
  logic [xlen-1:0] wr_data;
  logic [xlen-1:0] mem_addr;
  logic            mem_cyc;
  logic            mem_stb;
  logic            mem_we;
  logic [3:0]      mem_byte_en;

  logic [xlen-1:0] memory [0:mem_words-1];
  logic [xlen-1:0] exp_addr [0:max_stores-1];
  logic [xlen-1:0] exp_data [0:max_stores-1];
  logic [3:0]      exp_byte_en [0:max_stores-1];
  logic [15:0]     lfsr;
  int              expected_count;
  int              store_count;
  int              accesses;
  bit              finished;

  core #(
    .reset_addr(32'h0000_0000)
  ) i_core (
    .clock(clock),
    .reset(reset),
    .rd_data(rd_data),
    .mem_ack(mem_ack),
    .wr_data(wr_data),
    .mem_addr(mem_addr),
    .mem_cyc(mem_cyc),
    .mem_stb(mem_stb),
    .mem_we(mem_we),
    .mem_byte_en(mem_byte_en)
  );

  always #10 clock = ~clock;

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_error(input string reason);
    $display("error at %0t ns: %s", $time, reason);
    abort_run();
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] actual,
                            input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_byte_en(input string name, input logic [3:0] actual,
                               input logic [3:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      abort_run();
    end
  endtask

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic pick_delay(output int delay);
    lfsr = lfsr_next(lfsr);
    delay = lfsr[0];
    lfsr = lfsr_next(lfsr);
    delay = 2 * delay + lfsr[0];
  endtask

  function automatic logic [xlen-1:0] lane_mask(input logic [3:0] byte_en);
    logic [xlen-1:0] mask;
    int              lane;
    for (lane = 0; lane < 4; lane++) begin
      mask[8*lane +: 8] = {8{byte_en[lane]}};
    end
    return mask;
  endfunction

  task automatic load_expected();
    int entry;
    if ($isunknown(memory[list_base])) begin
      report_error("data file holds no expected store count");
    end
    expected_count = memory[list_base];
    if (expected_count > max_stores) begin
      report_error("expected store list in the data file is too long");
    end
    for (entry = 0; entry < expected_count; entry++) begin
      exp_addr[entry]    = memory[list_base + 1 + 3 * entry];
      exp_data[entry]    = memory[list_base + 2 + 3 * entry];
      exp_byte_en[entry] = memory[list_base + 3 + 3 * entry][3:0];
    end
  endtask

  task automatic wait_for_request();
    int cycles;
    cycles = 0;
    while (mem_stb !== 1'b1) begin
      if (cycles == request_timeout) begin
        report_error("core made no bus request within the timeout");
      end
      @(posedge clock);
      #1;
      cycles++;
    end
  endtask

  task automatic handle_write(input int index);
    int lane;
    if (mem_addr == finish_addr) begin
      finished = 1'b1;
    end else begin
      if (store_count >= expected_count) begin
        report_error($sformatf("store to %h beyond the expected list", mem_addr));
      end
      check_word("mem_addr", mem_addr, exp_addr[store_count]);
      // Disabled lanes carry no data
      check_word("wr_data", wr_data & lane_mask(mem_byte_en), exp_data[store_count]);
      check_byte_en("mem_byte_en", mem_byte_en, exp_byte_en[store_count]);
      store_count++;
      for (lane = 0; lane < 4; lane++) begin
        if (mem_byte_en[lane]) begin
          memory[index][8*lane +: 8] = wr_data[8*lane +: 8];
        end
      end
    end
  endtask

  task automatic serve_access();
    int delay;
    int index;
    wait_for_request();
    check_flag("mem_cyc", mem_cyc, 1'b1);
    if (mem_addr >= mem_words * 4) begin
      report_error($sformatf("bus access at %h lies outside the memory", mem_addr));
    end
    pick_delay(delay);
    repeat (delay) begin
      @(posedge clock);
      #1;
      check_flag("mem_stb", mem_stb, 1'b1);
    end
    index = mem_addr[9:2];
    if (mem_we) begin
      handle_write(index);
    end else begin
      rd_data = memory[index];
    end
    mem_ack = 1'b1;
    @(posedge clock);
    #1;
    mem_ack = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    rd_data = '0;
    mem_ack = 1'b0;
    lfsr = lfsr_seed;
    store_count = 0;
    accesses = 0;
    finished = 1'b0;
    $readmemh("verification/program_input.hex", memory);
    load_expected();

    repeat (8) begin
      @(posedge clock);
      #1;
      check_flag("mem_cyc", mem_cyc, 1'b0);
    end
    reset = 1'b0;

    // First access is the instruction read at the reset address
    wait_for_request();
    check_flag("mem_we", mem_we, 1'b0);
    check_word("mem_addr", mem_addr, 32'h0000_0000);

    while (!finished) begin
      if (accesses == access_limit) begin
        report_error("core never stored to the finish address");
      end
      serve_access();
      accesses++;
    end

    if (store_count == expected_count) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      report_error($sformatf("stores missing at finish: %0d of %0d seen",
                             store_count, expected_count));
    end
  end

endmodule

// ==== src/core.sv ====
// RV32I multicycle core: stage chain, register file and shared bus
`timescale 1ns/1ns

module core
  import core_pkg::*;
#(
  parameter logic [xlen-1:0] reset_addr = '0
) (
  input  logic            clock,
  input  logic            reset,
  input  logic [xlen-1:0] rd_data,
  input  logic            mem_ack,
  output logic [xlen-1:0] wr_data,
  output logic [xlen-1:0] mem_addr,
  output logic            mem_cyc,
  output logic            mem_stb,
  output logic            mem_we,
  output logic [3:0]      mem_byte_en
);

  // Fetch
  logic            fetch_rd_en;
  logic [xlen-1:0] fetch_addr;
  logic            fetch_done;
  instr_t          instr;
  logic [xlen-1:0] fetch_pc;

  // Decode
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_value;
  logic [xlen-1:0] rs2_value;
  logic            decode_done;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] dec_rs2_value;
  logic [xlen-1:0] imm;
  logic [3:0]      alu_op;
  logic [2:0]      dec_funct3;
  logic [4:0]      dec_rd;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            dec_is_load;
  logic            dec_is_store;
  logic            dec_writes_rd;
  logic [xlen-1:0] dec_pc;

  // Execute
  logic            exec_done;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] store_value;
  logic [2:0]      exe_funct3;
  logic [4:0]      exe_rd;
  logic            exe_is_load;
  logic            exe_is_store;
  logic            exe_writes_rd;
  logic [xlen-1:0] link_value;
  logic [xlen-1:0] next_pc;

  // Memory and writeback
  logic            mem_rd_en;
  logic            mem_wr_en;
  logic [xlen-1:0] mem_addr_out;
  logic [3:0]      byte_en;
  logic            retire;
  logic            reg_wr_en;
  logic [4:0]      reg_wr_addr;
  logic [xlen-1:0] reg_wr_data;

  fetch_stage #(
    .reset_addr(reset_addr)
  ) i_fetch (
    .clock(clock),
    .reset(reset),
    .retire(retire),
    .next_pc(next_pc),
    .mem_ack(mem_ack),
    .rd_data(rd_data),
    .fetch_rd_en(fetch_rd_en),
    .fetch_addr(fetch_addr),
    .fetch_done(fetch_done),
    .instr(instr),
    .pc(fetch_pc)
  );

  register_file i_regs (
    .clock(clock),
    .reset(reset),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .wr_en(reg_wr_en),
    .wr_addr(reg_wr_addr),
    .wr_data(reg_wr_data),
    .rs1_value(rs1_value),
    .rs2_value(rs2_value)
  );

  decode_stage i_decode (
    .clock(clock),
    .reset(reset),
    .fetch_done(fetch_done),
    .instr(instr),
    .pc(fetch_pc),
    .rs1_value(rs1_value),
    .rs2_value(rs2_value),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .decode_done(decode_done),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .rs2_value_out(dec_rs2_value),
    .imm(imm),
    .alu_op(alu_op),
    .funct3(dec_funct3),
    .rd(dec_rd),
    .is_branch(is_branch),
    .is_jal(is_jal),
    .is_jalr(is_jalr),
    .is_load(dec_is_load),
    .is_store(dec_is_store),
    .writes_rd(dec_writes_rd),
    .pc_out(dec_pc)
  );

  execute_stage i_execute (
    .clock(clock),
    .reset(reset),
    .decode_done(decode_done),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .rs2_value(dec_rs2_value),
    .imm(imm),
    .alu_op(alu_op),
    .funct3(dec_funct3),
    .rd(dec_rd),
    .is_branch(is_branch),
    .is_jal(is_jal),
    .is_jalr(is_jalr),
    .is_load(dec_is_load),
    .is_store(dec_is_store),
    .writes_rd(dec_writes_rd),
    .pc(dec_pc),
    .exec_done(exec_done),
    .alu_result(alu_result),
    .store_value(store_value),
    .funct3_out(exe_funct3),
    .rd_out(exe_rd),
    .is_load_out(exe_is_load),
    .is_store_out(exe_is_store),
    .writes_rd_out(exe_writes_rd),
    .link_value(link_value),
    .next_pc(next_pc)
  );

  memory_stage i_memory (
    .clock(clock),
    .reset(reset),
    .exec_done(exec_done),
    .alu_result(alu_result),
    .store_value(store_value),
    .funct3(exe_funct3),
    .rd(exe_rd),
    .is_load(exe_is_load),
    .is_store(exe_is_store),
    .writes_rd(exe_writes_rd),
    .link_value(link_value),
    .mem_ack(mem_ack),
    .rd_data(rd_data),
    .mem_rd_en(mem_rd_en),
    .mem_wr_en(mem_wr_en),
    .mem_addr_out(mem_addr_out),
    .wr_data(wr_data),
    .byte_en(byte_en),
    .retire(retire),
    .reg_wr_en(reg_wr_en),
    .reg_wr_addr(reg_wr_addr),
    .reg_wr_data(reg_wr_data)
  );

  // Only one requester is active at a time
  assign mem_addr    = fetch_rd_en ? fetch_addr : mem_addr_out;
  assign mem_byte_en = fetch_rd_en ? 4'b1111 : byte_en;
  assign mem_cyc     = fetch_rd_en | mem_rd_en | mem_wr_en;
  assign mem_stb     = mem_cyc;
  assign mem_we      = mem_wr_en;

endmodule

// ==== src/memory_stage.sv ====
// Memory stage: load/store bus access with byte lanes, load extension
// and register writeback
`timescale 1ns/1ns

module memory_stage
  import core_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            exec_done,
  input  logic [xlen-1:0] alu_result,
  input  logic [xlen-1:0] store_value,
  input  logic [2:0]      funct3,
  input  logic [4:0]      rd,
  input  logic            is_load,
  input  logic            is_store,
  input  logic            writes_rd,
  input  logic [xlen-1:0] link_value,
  input  logic            mem_ack,
  input  logic [xlen-1:0] rd_data,
  output logic            mem_rd_en,
  output logic            mem_wr_en,
  output logic [xlen-1:0] mem_addr_out,
  output logic [xlen-1:0] wr_data,
  output logic [3:0]      byte_en,
  output logic            retire,
  output logic            reg_wr_en,
  output logic [4:0]      reg_wr_addr,
  output logic [xlen-1:0] reg_wr_data
);

  logic [1:0]      offset;
  logic [xlen-1:0] lane_data;
  logic [xlen-1:0] load_value;
  logic            acked;

  assign offset       = alu_result[1:0];
  assign mem_addr_out = {alu_result[xlen-1:2], 2'b00};
  assign acked        = (mem_rd_en || mem_wr_en) && mem_ack;

  // Replicate narrow data so it sits on every lane
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        wr_data = {4{store_value[7:0]}};
        byte_en = 4'b0001 << offset;
      end
      2'b01: begin
        wr_data = {2{store_value[15:0]}};
        byte_en = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wr_data = store_value;
        byte_en = 4'b1111;
      end
    endcase
  end

  assign lane_data = rd_data >> {offset, 3'b000};

  always_comb begin
    case (funct3)
      3'b000:  load_value = {{24{lane_data[7]}}, lane_data[7:0]};
      3'b001:  load_value = {{16{lane_data[15]}}, lane_data[15:0]};
      3'b100:  load_value = {24'b0, lane_data[7:0]};
      3'b101:  load_value = {16'b0, lane_data[15:0]};
      default: load_value = rd_data;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_rd_en <= 1'b0;
      mem_wr_en <= 1'b0;
      retire    <= 1'b0;
      reg_wr_en <= 1'b0;
    end else begin
      retire    <= 1'b0;
      reg_wr_en <= 1'b0;
      if (exec_done) begin
        mem_rd_en <= is_load;
        mem_wr_en <= is_store;
        if (!is_load && !is_store) begin
          retire    <= 1'b1;
          reg_wr_en <= writes_rd;
        end
      end else if (acked) begin
        mem_rd_en <= 1'b0;
        mem_wr_en <= 1'b0;
        retire    <= 1'b1;
        reg_wr_en <= writes_rd;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (exec_done) begin
      reg_wr_addr <= rd;
      reg_wr_data <= link_value;
    end else if (acked && mem_rd_en) begin
      reg_wr_data <= load_value;
    end
  end

endmodule

// ==== src/execute_stage.sv ====
// Execute stage: ALU, branch compare and next-PC selection
`timescale 1ns/1ns

module execute_stage
  import core_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            decode_done,
  input  logic [xlen-1:0] operand_a,
  input  logic [xlen-1:0] operand_b,
  input  logic [xlen-1:0] rs2_value,
  input  logic [xlen-1:0] imm,
  input  logic [3:0]      alu_op,
  input  logic [2:0]      funct3,
  input  logic [4:0]      rd,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  logic            is_load,
  input  logic            is_store,
  input  logic            writes_rd,
  input  logic [xlen-1:0] pc,
  output logic            exec_done,
  output logic [xlen-1:0] alu_result,
  output logic [xlen-1:0] store_value,
  output logic [2:0]      funct3_out,
  output logic [4:0]      rd_out,
  output logic            is_load_out,
  output logic            is_store_out,
  output logic            writes_rd_out,
  output logic [xlen-1:0] link_value,
  output logic [xlen-1:0] next_pc
);

  logic [xlen-1:0] alu_value;
  logic [xlen-1:0] pc_plus_4;
  logic [xlen-1:0] target;
  logic [4:0]      shamt;
  logic            taken;

  assign shamt     = operand_b[4:0];
  assign pc_plus_4 = pc + 32'd4;

  always_comb begin
    case (alu_op)
      alu_add:    alu_value = operand_a + operand_b;
      alu_sub:    alu_value = operand_a - operand_b;
      alu_sll:    alu_value = operand_a << shamt;
      alu_slt:    alu_value = {31'b0, $signed(operand_a) < $signed(operand_b)};
      alu_sltu:   alu_value = {31'b0, operand_a < operand_b};
      alu_xor:    alu_value = operand_a ^ operand_b;
      alu_srl:    alu_value = operand_a >> shamt;
      alu_sra:    alu_value = $signed(operand_a) >>> shamt;
      alu_or:     alu_value = operand_a | operand_b;
      alu_and:    alu_value = operand_a & operand_b;
      alu_pass_b: alu_value = operand_b;
      default:    alu_value = '0;
    endcase
  end

  // Operand A holds rs1 for branches
  always_comb begin
    case (funct3)
      3'b000:  taken = (operand_a == rs2_value);
      3'b001:  taken = (operand_a != rs2_value);
      3'b100:  taken = $signed(operand_a) < $signed(rs2_value);
      3'b101:  taken = $signed(operand_a) >= $signed(rs2_value);
      3'b110:  taken = operand_a < rs2_value;
      3'b111:  taken = operand_a >= rs2_value;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jal || (is_branch && taken)) begin
      target = pc + imm;
    end else if (is_jalr) begin
      target = {alu_value[xlen-1:1], 1'b0};
    end else begin
      target = pc_plus_4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      exec_done <= 1'b0;
    end else begin
      exec_done <= decode_done;
    end
  end

  always_ff @(posedge clock) begin
    if (decode_done) begin
      alu_result    <= alu_value;
      store_value   <= rs2_value;
      funct3_out    <= funct3;
      rd_out        <= rd;
      is_load_out   <= is_load;
      is_store_out  <= is_store;
      writes_rd_out <= writes_rd;
      // Jumps write back the return address
      link_value    <= (is_jal || is_jalr) ? pc_plus_4 : alu_value;
      next_pc       <= target;
    end
  end

endmodule

// ==== src/decode_stage.sv ====
// Decode stage: immediate generation, operand selection, ALU code
// and instruction class flags
`timescale 1ns/1ns

module decode_stage
  import core_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            fetch_done,
  input  instr_t          instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_value,
  input  logic [xlen-1:0] rs2_value,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  output logic            decode_done,
  output logic [xlen-1:0] operand_a,
  output logic [xlen-1:0] operand_b,
  output logic [xlen-1:0] rs2_value_out,
  output logic [xlen-1:0] imm,
  output logic [3:0]      alu_op,
  output logic [2:0]      funct3,
  output logic [4:0]      rd,
  output logic            is_branch,
  output logic            is_jal,
  output logic            is_jalr,
  output logic            is_load,
  output logic            is_store,
  output logic            writes_rd,
  output logic [xlen-1:0] pc_out
);

  logic [6:0]      opcode;
  logic [xlen-1:0] imm_value;
  logic [xlen-1:0] a_value;
  logic [xlen-1:0] b_value;
  logic [3:0]      alu_value;
  logic            alt;

  assign opcode   = instr.r_fmt.opcode;
  assign rs1_addr = instr.r_fmt.rs1;
  assign rs2_addr = instr.r_fmt.rs2;
  // Bit 30 selects sub and sra
  assign alt      = instr.r_fmt.funct7[5];

  always_comb begin
    case (opcode)
      op_imm, op_load, op_jalr: begin
        imm_value = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
      end
      op_store: begin
        imm_value = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                     instr.s_fmt.imm_4_0};
      end
      op_branch: begin
        imm_value = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                     instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
      end
      op_lui, op_auipc: imm_value = {instr.u_fmt.imm_31_12, 12'b0};
      op_jal: begin
        imm_value = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                     instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
      end
      default: imm_value = '0;
    endcase
  end

  // Branches keep rs1 in operand A for the compare
  always_comb begin
    case (opcode)
      op_auipc, op_jal: a_value = pc;
      op_lui:           a_value = '0;
      default:          a_value = rs1_value;
    endcase
  end

  assign b_value = (opcode == op_reg || opcode == op_branch) ? rs2_value : imm_value;

  always_comb begin
    alu_value = alu_add;
    if (opcode == op_reg || opcode == op_imm) begin
      case (instr.r_fmt.funct3)
        3'b000: alu_value = (opcode == op_reg && alt) ? alu_sub : alu_add;
        3'b001: alu_value = alu_sll;
        3'b010: alu_value = alu_slt;
        3'b011: alu_value = alu_sltu;
        3'b100: alu_value = alu_xor;
        3'b101: alu_value = alt ? alu_sra : alu_srl;
        3'b110: alu_value = alu_or;
        default: alu_value = alu_and;
      endcase
    end else if (opcode == op_lui) begin
      alu_value = alu_pass_b;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      decode_done <= 1'b0;
    end else begin
      decode_done <= fetch_done;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_done) begin
      operand_a     <= a_value;
      operand_b     <= b_value;
      rs2_value_out <= rs2_value;
      imm           <= imm_value;
      alu_op        <= alu_value;
      funct3        <= instr.r_fmt.funct3;
      rd            <= instr.r_fmt.rd;
      pc_out        <= pc;
      is_branch     <= (opcode == op_branch);
      is_jal        <= (opcode == op_jal);
      is_jalr       <= (opcode == op_jalr);
      is_load       <= (opcode == op_load);
      is_store      <= (opcode == op_store);
      // Unknown opcodes write nothing and retire as no-ops
      writes_rd     <= opcode inside {op_lui, op_auipc, op_jal, op_jalr,
                                      op_load, op_imm, op_reg};
    end
  end

endmodule

// ==== src/register_file.sv ====
// Integer register file: x1..x31, x0 hardwired to zero,
// two combinational read ports and one write port
`timescale 1ns/1ns

module register_file
  import core_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  input  logic            wr_en,
  input  logic [4:0]      wr_addr,
  input  logic [xlen-1:0] wr_data,
  output logic [xlen-1:0] rs1_value,
  output logic [xlen-1:0] rs2_value
);

  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != 5'd0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_value = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_value = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/fetch_stage.sv ====
// Fetch stage: program counter, instruction read request and
// instruction latch
`timescale 1ns/1ns

module fetch_stage
  import core_pkg::*;
#(
  parameter logic [xlen-1:0] reset_addr = '0
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            retire,
  input  logic [xlen-1:0] next_pc,
  input  logic            mem_ack,
  input  logic [xlen-1:0] rd_data,
  output logic            fetch_rd_en,
  output logic [xlen-1:0] fetch_addr,
  output logic            fetch_done,
  output instr_t          instr,
  output logic [xlen-1:0] pc
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait
  } fetch_state_t;

  fetch_state_t state;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_idle;
      pc         <= reset_addr;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      case (state)
        st_idle: state <= st_request;
        st_request: begin
          if (mem_ack) begin
            state      <= st_wait;
            fetch_done <= 1'b1;
          end
        end
        // Hold until the instruction has gone through all stages
        st_wait: begin
          if (retire) begin
            state <= st_request;
            pc    <= next_pc;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_request && mem_ack) begin
      instr <= rd_data;
    end
  end

  assign fetch_rd_en = (state == st_request);
  assign fetch_addr  = pc;

endmodule

// ==== src/core_pkg.sv ====
// Shared definitions for the RV32I core: word width, opcodes, ALU codes
// and the instruction-format union
package core_pkg;

  localparam int xlen = 32;

  // Major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // ALU operations
  localparam logic [3:0] alu_add    = 4'd0;
  localparam logic [3:0] alu_sub    = 4'd1;
  localparam logic [3:0] alu_sll    = 4'd2;
  localparam logic [3:0] alu_slt    = 4'd3;
  localparam logic [3:0] alu_sltu   = 4'd4;
  localparam logic [3:0] alu_xor    = 4'd5;
  localparam logic [3:0] alu_srl    = 4'd6;
  localparam logic [3:0] alu_sra    = 4'd7;
  localparam logic [3:0] alu_or     = 4'd8;
  localparam logic [3:0] alu_and    = 4'd9;
  localparam logic [3:0] alu_pass_b = 4'd10;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, viewed in each encoding format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage
